/* ternary_matmul_top.f */
verilog/matmul_pkg.sv
verilog/weight_unpack.sv
verilog/operand_buffer.sv
verilog/mac_array.sv
verilog/result_queue.sv
verilog/readout_ctrl.sv
verilog/ternary_matmul_top.sv
sim/ternary_matmul_tb.sv

/* Bender.yml */
package:
  name: ternary_matmul

sources:
  - verilog/matmul_pkg.sv
  - verilog/weight_unpack.sv
  - verilog/operand_buffer.sv
  - verilog/mac_array.sv
  - verilog/result_queue.sv
  - verilog/readout_ctrl.sv
  - verilog/ternary_matmul_top.sv
  - target: simulation
    files:
      - sim/ternary_matmul_tb.sv

/* sim/ternary_matmul_tb.sv */
// clock, reset, reference model, directed tests and result checking for the matmul engine
`default_nettype none
`timescale 1ns/1ns

module ternary_matmul_tb;

    // six tests of up to three groups each plus their readouts stay well below this
    localparam int CYCLE_LIMIT = 4000;
    localparam int ACK_LIMIT = 8;

    logic clk = 1'b0;
    logic reset;
    matmul_pkg::packed_weights_t weights;
    matmul_pkg::act_t act;
    logic read_req;
    logic read_ack;
    matmul_pkg::acc_t result;
    logic result_valid;

    int seed;
    int phase;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    string test_name;

    // reference accumulators and the group being sent
    int model_acc[matmul_pkg::ROWS][matmul_pkg::COLS];
    int group_w[matmul_pkg::SLICES];
    int group_a[matmul_pkg::SLICES];
    int got[$];

    ternary_matmul_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .weights      (weights),
        .act          (act),
        .read_req     (read_req),
        .read_ack     (read_ack),
        .result       (result),
        .result_valid (result_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // phase is the slice counter value that the next edge will see
    task automatic step_cycle();
        @(posedge clk);
        phase = (phase + 1) % matmul_pkg::SLICES;
        #1;
    endtask

    // weight times two so that the halves stay integers
    function automatic int weight_x2(input int code, input int pos);
        int digit;
        weight_x2 = 0;
        if (code < int'(matmul_pkg::WEIGHT_CODES)) begin
            if (pos == 2) begin
                digit = code % 5;
                case (digit)
                    1: weight_x2 = 2;
                    2: weight_x2 = 4;
                    3: weight_x2 = -2;
                    4: weight_x2 = -4;
                    default: weight_x2 = 0;
                endcase
            end else begin
                digit = (pos == 1) ? (code / 5) % 7 : code / 35;
                case (digit)
                    1: weight_x2 = 1;
                    2: weight_x2 = 2;
                    3: weight_x2 = 4;
                    4: weight_x2 = -1;
                    5: weight_x2 = -2;
                    6: weight_x2 = -4;
                    default: weight_x2 = 0;
                endcase
            end
        end
    endfunction

    // halving rounds toward minus infinity and the sign is applied afterwards
    function automatic int product(input int w2, input int a);
        int w_abs;
        int mag;
        w_abs = (w2 < 0) ? -w2 : w2;
        if (w_abs == 1) begin
            mag = a >>> 1;
        end else begin
            mag = a * w_abs / 2;
        end
        product = (w2 < 0) ? -mag : mag;
    endfunction

    function automatic int rand_code(input int lo, input int span);
        int r;
        r = $random(seed);
        rand_code = lo + ((r & 32'h7fff_ffff) % span);
    endfunction

    function automatic int rand_act();
        int r;
        r = $random(seed);
        rand_act = (r & 32'hff) - 128;
    endfunction

    task automatic clear_model();
        foreach (model_acc[i, j]) begin
            model_acc[i][j] = 0;
        end
    endtask

    task automatic fill_group(input int code_lo, input int code_span);
        for (int k = 0; k < matmul_pkg::SLICES; k++) begin
            group_w[k] = rand_code(code_lo, code_span);
            group_a[k] = rand_act();
        end
    endtask

    // waits for slice 0, sends one group and adds it into the model
    task automatic feed_group();
        int row;
        weights = '0;
        act = '0;
        while (phase != 0) begin
            step_cycle();
        end
        for (int k = 0; k < matmul_pkg::SLICES; k++) begin
            weights = matmul_pkg::packed_weights_t'(group_w[k]);
            act = matmul_pkg::act_t'(group_a[k]);
            step_cycle();
            for (int pos = 0; pos < matmul_pkg::WEIGHTS_PER_BYTE; pos++) begin
                row = matmul_pkg::WEIGHTS_PER_BYTE * k + pos;
                for (int j = 0; j < matmul_pkg::COLS; j++) begin
                    model_acc[row][j] += product(weight_x2(group_w[k], pos), group_a[j]);
                end
            end
        end
        weights = '0;
        act = '0;
    endtask

    task automatic idle();
        weights = '0;
        act = '0;
        repeat (2 * matmul_pkg::SLICES) step_cycle();
    endtask

    // full handshake; req stays high for hold_cycles after the drain
    task automatic do_readout(input int hold_cycles);
        int waited;
        got.delete();
        read_req = 1'b1;
        waited = 0;
        while (!read_ack && waited < ACK_LIMIT) begin
            step_cycle();
            waited++;
            // second edge carries read_start, which restarts the slice counter
            if (waited == 2) begin
                phase = 0;
            end
        end
        if (!read_ack) begin
            error_count++;
            $display("%s: read_ack never rose after read_req", test_name);
            read_req = 1'b0;
            return;
        end
        check({test_name, " ack latency"}, 3, waited);
        while (result_valid) begin
            got.push_back(int'(result));
            check({test_name, " ack during drain"}, 1, int'(read_ack));
            step_cycle();
        end
        repeat (hold_cycles) begin
            check({test_name, " ack while req held"}, 1, int'(read_ack));
            step_cycle();
        end
        read_req = 1'b0;
        waited = 0;
        while (read_ack && waited < ACK_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (read_ack) begin
            error_count++;
            $display("%s: read_ack stayed high after read_req dropped", test_name);
        end else begin
            // req is sampled low on the first edge and ack drops on the next
            check({test_name, " ack release"}, 2, waited);
        end
        if (got.size() != matmul_pkg::NUM_RESULTS) begin
            error_count++;
            $display("%s: got %0d results instead of %0d", test_name, got.size(),
                     matmul_pkg::NUM_RESULTS);
        end
    endtask

    // results arrive row-major; the readout also clears the model
    task automatic compare_results();
        for (int n = 0; n < got.size() && n < matmul_pkg::NUM_RESULTS; n++) begin
            check($sformatf("%s result %0d", test_name, n),
                  model_acc[n / matmul_pkg::COLS][n % matmul_pkg::COLS], got[n]);
        end
        clear_model();
    endtask

    task automatic readout_after_reset();
        test_name = "reset_state";
        check({test_name, " read_ack"}, 0, int'(read_ack));
        check({test_name, " result_valid"}, 0, int'(result_valid));
        do_readout(0);
        compare_results();
    endtask

    task automatic all_ones_group();
        test_name = "all_ones";
        for (int k = 0; k < matmul_pkg::SLICES; k++) begin
            group_w[k] = 81;
            group_a[k] = 17 * k - 50;
        end
        feed_group();
        idle();
        do_readout(0);
        // every weight is 1 so each row repeats the activations
        for (int n = 0; n < got.size() && n < matmul_pkg::NUM_RESULTS; n++) begin
            check($sformatf("%s result %0d", test_name, n),
                  group_a[n % matmul_pkg::COLS], got[n]);
        end
        clear_model();
    endtask

    task automatic random_group();
        test_name = "random_group";
        fill_group(0, int'(matmul_pkg::WEIGHT_CODES));
        feed_group();
        idle();
        do_readout(0);
        compare_results();
    endtask

    task automatic unused_codes();
        test_name = "unused_codes";
        fill_group(int'(matmul_pkg::WEIGHT_CODES), 256 - int'(matmul_pkg::WEIGHT_CODES));
        feed_group();
        idle();
        do_readout(0);
        compare_results();
    endtask

    task automatic accumulate_and_clear();
        test_name = "accumulate";
        repeat (3) begin
            fill_group(0, int'(matmul_pkg::WEIGHT_CODES));
            feed_group();
        end
        idle();
        do_readout(0);
        compare_results();
        test_name = "after_clear";
        fill_group(0, int'(matmul_pkg::WEIGHT_CODES));
        feed_group();
        idle();
        do_readout(0);
        compare_results();
    endtask

    task automatic handshake_hold();
        test_name = "handshake";
        fill_group(0, int'(matmul_pkg::WEIGHT_CODES));
        feed_group();
        idle();
        do_readout(6);
        compare_results();
    endtask

    initial begin
        seed = 32'he383;
        reset = 1'b1;
        weights = '0;
        act = '0;
        read_req = 1'b0;
        clear_model();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        phase = 0;

        readout_after_reset();
        all_ones_group();
        random_group();
        unused_codes();
        accumulate_and_clear();
        handshake_hold();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ternary_matmul_top.sv */
// ternary_matmul_top: weight decode, operand capture, MAC array, readout and output queue
`default_nettype none
`timescale 1ns/1ns

module ternary_matmul_top (
    input  logic                        clk,
    input  logic                        reset,
    input  matmul_pkg::packed_weights_t weights,
    input  matmul_pkg::act_t            act,
    input  logic                        read_req,
    output logic                        read_ack,
    output matmul_pkg::acc_t            result,
    output logic                        result_valid
);

    matmul_pkg::byte_ops_t byte_ops;
    matmul_pkg::tile_ops_t cur_ops;
    matmul_pkg::act_t cur_act;
    matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] snapshot;
    logic read_start;
    logic drain_busy;

    weight_unpack u_unpack (
        .packed_weights (weights),
        .ops            (byte_ops)
    );

    operand_buffer u_operands (
        .clk        (clk),
        .reset      (reset),
        .read_start (read_start),
        .byte_ops   (byte_ops),
        .act        (act),
        .cur_ops    (cur_ops),
        .cur_act    (cur_act)
    );

    mac_array u_mac (
        .clk        (clk),
        .reset      (reset),
        .read_start (read_start),
        .cur_ops    (cur_ops),
        .cur_act    (cur_act),
        .snapshot   (snapshot)
    );

    result_queue u_queue (
        .clk          (clk),
        .reset        (reset),
        .read_start   (read_start),
        .snapshot     (snapshot),
        .result       (result),
        .result_valid (result_valid),
        .drain_busy   (drain_busy)
    );

    readout_ctrl u_readout (
        .clk        (clk),
        .reset      (reset),
        .read_req   (read_req),
        .drain_busy (drain_busy),
        .read_start (read_start),
        .read_ack   (read_ack)
    );

endmodule

`default_nettype wire

/* verilog/readout_ctrl.sv */
// readout_ctrl: four-phase req/ack FSM that issues the readout start pulse
`default_nettype none
`timescale 1ns/1ns

module readout_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic read_req,
    input  logic drain_busy,
    output logic read_start,
    output logic read_ack
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        HOLD
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            // ack still high means the last handshake has not closed yet
            IDLE: if (read_req && !read_ack) state_next = START;
            START: state_next = HOLD;
            HOLD: if (!read_req && !drain_busy) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            read_ack <= 1'b0;
        end else begin
            state <= state_next;
            read_ack <= (state == HOLD);
        end
    end

    assign read_start = (state == START);

    ack_held_with_req: assert property (
        @(posedge clk) disable iff (reset) read_ack && read_req |=> read_ack
    ) else $error("read_ack dropped while read_req still high");

endmodule

`default_nettype wire

/* verilog/result_queue.sv */
// result_queue: output shift queue loaded from the snapshot, with drain counter
`default_nettype none
`timescale 1ns/1ns

module result_queue (
    input  logic             clk,
    input  logic             reset,
    input  logic             read_start,
    input  matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] snapshot,
    output matmul_pkg::acc_t result,
    output logic             result_valid,
    output logic             drain_busy
);

    matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] queue;
    matmul_pkg::drain_cnt_t drain_cnt;

    // entry 0 is the next result to leave
    always_ff @(posedge clk) begin
        if (read_start) begin
            queue <= snapshot;
        end else begin
            queue <= {matmul_pkg::acc_t'(0), queue[matmul_pkg::NUM_RESULTS-1:1]};
        end
        result <= queue[0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_cnt <= '0;
        end else if (read_start) begin
            drain_cnt <= matmul_pkg::DRAIN_COUNT;
        end else if (drain_busy) begin
            drain_cnt <= drain_cnt - 1'b1;
        end
    end

    assign drain_busy = (drain_cnt != '0);

    // result is registered, so valid follows busy by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= drain_busy;
        end
    end

    no_reload_in_drain: assert property (
        @(posedge clk) disable iff (reset) read_start |-> !drain_busy
    ) else $error("readout started while queue still draining");

endmodule

`default_nettype wire

/* verilog/mac_array.sv */
// mac_array: rotating accumulator rows with one shared adder each, and the aligned snapshot
`default_nettype none
`timescale 1ns/1ns

module mac_array (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_start,
    input  matmul_pkg::tile_ops_t cur_ops,
    input  matmul_pkg::act_t      cur_act,
    output matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] snapshot
);

    matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] acc_q;
    matmul_pkg::acc_t [matmul_pkg::NUM_RESULTS-1:0] acc_next;
    matmul_pkg::addend_t act_ext;
    logic [matmul_pkg::ROWS-1:0] both_set;

    // rotation phase, runs in step with the slice counter
    matmul_pkg::slice_idx_t rot_phase;

    assign act_ext = {cur_act[$bits(cur_act)-1], cur_act};

    for (genvar i = 0; i < matmul_pkg::ROWS; i++) begin : g_row
        localparam int BASE = i * matmul_pkg::COLS;
        matmul_pkg::addend_t addend;

        assign addend = cur_ops[i].mul2 ? act_ext <<< 1 :
                        cur_ops[i].div2 ? act_ext >>> 1 :
                                          act_ext;

        // slot 0 goes through the adder and wraps to the top slot
        assign acc_next[BASE+matmul_pkg::COLS-1] =
            cur_ops[i].zero ? acc_q[BASE] :
            cur_ops[i].sign ? acc_q[BASE] - matmul_pkg::acc_t'(addend) :
                              acc_q[BASE] + matmul_pkg::acc_t'(addend);

        for (genvar j = 1; j < matmul_pkg::COLS; j++) begin : g_shift
            assign acc_next[BASE+j-1] = acc_q[BASE+j];
        end

        assign both_set[i] = cur_ops[i].mul2 & cur_ops[i].div2;
    end

    always_ff @(posedge clk) begin
        if (reset || read_start || rot_phase == matmul_pkg::LAST_SLICE) begin
            rot_phase <= '0;
        end else begin
            rot_phase <= rot_phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || read_start) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_next;
        end
    end

    // acc_next is one rotation step past the current phase,
    // so column j of a row sits in slot (j - phase - 1) mod COLS
    always_comb begin
        snapshot = '0;
        for (int c = 0; c < matmul_pkg::COLS; c++) begin
            if (rot_phase == matmul_pkg::slice_idx_t'(c)) begin
                for (int i = 0; i < matmul_pkg::ROWS; i++) begin
                    for (int j = 0; j < matmul_pkg::COLS; j++) begin
                        snapshot[i*matmul_pkg::COLS+j] =
                            acc_next[i*matmul_pkg::COLS +
                                     (j + 2*matmul_pkg::COLS - 1 - c) % matmul_pkg::COLS];
                    end
                end
            end
        end
    end

    // decoder must never ask for both x2 and x1/2
    lane_scale_onehot: assert property (
        @(posedge clk) disable iff (reset) both_set == '0
    ) else $error("lane with both mul2 and div2 set");

endmodule

`default_nettype wire

/* verilog/operand_buffer.sv */
// operand_buffer: slice counter, next/current weight tiles and the activation line
`default_nettype none
`timescale 1ns/1ns

module operand_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_start,
    input  matmul_pkg::byte_ops_t byte_ops,
    input  matmul_pkg::act_t      act,
    output matmul_pkg::tile_ops_t cur_ops,
    output matmul_pkg::act_t      cur_act
);

    matmul_pkg::slice_idx_t slice_cnt;

    // group being captured
    matmul_pkg::tile_ops_t ops_next;
    matmul_pkg::act_t [matmul_pkg::COLS-1:0] act_next;

    // tile being worked on
    matmul_pkg::tile_ops_t ops_cur;
    matmul_pkg::act_t [matmul_pkg::COLS-1:0] act_line;

    always_ff @(posedge clk) begin
        if (reset || read_start || slice_cnt == matmul_pkg::LAST_SLICE) begin
            slice_cnt <= '0;
        end else begin
            slice_cnt <= slice_cnt + 1'b1;
        end
    end

    // newest byte enters at the top, so byte k ends up in rows 3k+2..3k
    always_ff @(posedge clk) begin
        if (reset) begin
            ops_next <= {matmul_pkg::ROWS{matmul_pkg::LANE_IDLE}};
            act_next <= '0;
        end else begin
            ops_next <= {byte_ops, ops_next[matmul_pkg::ROWS-1:matmul_pkg::WEIGHTS_PER_BYTE]};
            act_next <= {act, act_next[matmul_pkg::COLS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ops_cur <= {matmul_pkg::ROWS{matmul_pkg::LANE_IDLE}};
            act_line <= '0;
        end else if (slice_cnt == '0) begin
            ops_cur <= ops_next;
            // column 1 is used first and column 0 last,
            // matching the accumulator rotation
            act_line <= {act_next[0], act_next[matmul_pkg::COLS-1:1]};
        end else begin
            act_line <= {matmul_pkg::act_t'(0), act_line[matmul_pkg::COLS-1:1]};
        end
    end

    assign cur_ops = ops_cur;
    assign cur_act = act_line[0];

    slice_cnt_range: assert property (
        @(posedge clk) disable iff (reset) slice_cnt <= matmul_pkg::LAST_SLICE
    ) else $error("slice counter out of range");

endmodule

`default_nettype wire

/* verilog/weight_unpack.sv */
// weight_unpack: splits a packed weight byte into three lane operations
`default_nettype none
`timescale 1ns/1ns

module weight_unpack (
    input  matmul_pkg::packed_weights_t packed_weights,
    output matmul_pkg::byte_ops_t       ops
);

    logic [7:0] by5;
    logic [2:0] digit1;
    logic [2:0] digit2;
    logic [2:0] digit3;

    // base-5 digit: 0, 1, 2, -1, -2
    function automatic matmul_pkg::lane_op_t quinary_op(input logic [2:0] digit);
        matmul_pkg::lane_op_t op;
        op = '0;
        case (digit)
            3'd0: op.zero = 1'b1;
            3'd2: op.mul2 = 1'b1;
            3'd3: op.sign = 1'b1;
            3'd4: begin
                op.sign = 1'b1;
                op.mul2 = 1'b1;
            end
            default: op = '0;
        endcase
        return op;
    endfunction

    // base-7 digit: 0, 1/2, 1, 2, -1/2, -1, -2
    function automatic matmul_pkg::lane_op_t septenary_op(input logic [2:0] digit);
        matmul_pkg::lane_op_t op;
        op = '0;
        op.sign = (digit >= 3'd4);
        case (digit)
            3'd0: op.zero = 1'b1;
            3'd1, 3'd4: op.div2 = 1'b1;
            3'd3, 3'd6: op.mul2 = 1'b1;
            default: op.zero = 1'b0;
        endcase
        return op;
    endfunction

    // byte = d1 + 5*d2 + 35*d3
    assign by5 = packed_weights / 8'd5;
    assign digit1 = 3'(packed_weights % 8'd5);
    assign digit2 = 3'(by5 % 8'd7);
    assign digit3 = 3'(by5 / 8'd7);

    always_comb begin
        if (packed_weights < matmul_pkg::WEIGHT_CODES) begin
            ops[2] = quinary_op(digit1);
            ops[1] = septenary_op(digit2);
            ops[0] = septenary_op(digit3);
        end else begin
            // unused codes behave as three zero weights
            ops = {3{matmul_pkg::LANE_IDLE}};
        end
    end

endmodule

`default_nettype wire

/* verilog/matmul_pkg.sv */
// matmul engine sizes, operand typedefs and per-weight lane controls
`default_nettype none

package matmul_pkg;

    // tile geometry
    localparam int SLICES = 7;
    localparam int WEIGHTS_PER_BYTE = 3;
    localparam int COLS = SLICES;
    localparam int ROWS = WEIGHTS_PER_BYTE * SLICES;
    localparam int ACC_W = 18;
    localparam int NUM_RESULTS = ROWS * COLS;

    typedef logic [7:0] packed_weights_t;
    typedef logic signed [7:0] act_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [$clog2(SLICES)-1:0] slice_idx_t;

    // activation widened by one bit so that x2 still fits
    typedef logic signed [$bits(act_t):0] addend_t;

    // counts the results still to leave the output queue
    typedef logic [$clog2(NUM_RESULTS + 1)-1:0] drain_cnt_t;

    // controls for one weight; all clear means a weight of +1
    typedef struct packed {
        logic zero;
        logic sign;
        logic mul2;
        logic div2;
    } lane_op_t;

    // index 2 holds the first digit of the byte
    typedef lane_op_t [WEIGHTS_PER_BYTE-1:0] byte_ops_t;
    typedef lane_op_t [ROWS-1:0] tile_ops_t;

    localparam slice_idx_t LAST_SLICE = slice_idx_t'(SLICES - 1);
    localparam drain_cnt_t DRAIN_COUNT = drain_cnt_t'(NUM_RESULTS);

    // 5 x 7 x 7 digit combinations, higher byte values are unused
    localparam packed_weights_t WEIGHT_CODES = packed_weights_t'(5 * 7 * 7);

    // weight of zero, contributes nothing
    localparam lane_op_t LANE_IDLE = '{zero: 1'b1, sign: 1'b0, mul2: 1'b0, div2: 1'b0};

endpackage

`default_nettype wire
